/* files.f */
radio_pkg.sv
radio_settings.sv
radio_tx_ctrl.sv
radio_rx_ctrl.sv
radio_resp_mux.sv
radio_core.sv
tb_radio_core.sv

/* radio_core.sv */
// Radio core top: loopback select, SID pairs, settings, TX and RX control, response merge
`timescale 1ns/1ns
module radio_core #(
  parameter int RADIO_NUM = 0
) (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic                           i_clear_tx,
  input  logic                           i_clear_rx,
  input  logic [15:0]                    i_src_sid,
  input  logic [15:0]                    i_tx_resp_dst_sid,
  input  logic [15:0]                    i_rx_resp_dst_sid,
  input  logic [radio_pkg::TIME_W-1:0]   i_vita_time,
  // Converter side
  input  logic [radio_pkg::SAMPLE_W-1:0] i_rx,
  input  logic                           i_rx_stb,
  output logic [radio_pkg::SAMPLE_W-1:0] o_tx,
  input  logic                           i_tx_stb,
  // Settings and readback
  input  logic                           i_set_stb,
  input  logic [7:0]                     i_set_addr,
  input  logic [31:0]                    i_set_data,
  input  logic [7:0]                     i_rb_addr,
  output logic [63:0]                    o_rb_data,
  // Host streams
  input  logic [radio_pkg::SAMPLE_W-1:0] i_tx_tdata,
  input  logic                           i_tx_tlast,
  input  logic                           i_tx_tvalid,
  output logic                           o_tx_tready,
  output logic [radio_pkg::SAMPLE_W-1:0] o_rx_tdata,
  output logic                           o_rx_tlast,
  output logic                           o_rx_tvalid,
  input  logic                           i_rx_tready,
  output logic [radio_pkg::RESP_W-1:0]   o_resp_tdata,
  output logic                           o_resp_tlast,
  output logic                           o_resp_tvalid,
  input  logic                           i_resp_tready
);
  import radio_pkg::*;

  logic                loopback;
  logic [SAMPLE_W-1:0] tx_idle;
  logic [SAMPLE_W-1:0] rx_sample;
  logic                rx_sample_stb;
  logic [RESP_W-1:0]   txresp_tdata;
  logic                txresp_tlast;
  logic                txresp_tvalid;
  logic                txresp_tready;
  logic [RESP_W-1:0]   rxresp_tdata;
  logic                rxresp_tlast;
  logic                rxresp_tvalid;
  logic                rxresp_tready;

  // Digital loopback, DAC word and its strobe feed RX
  assign rx_sample     = loopback ? o_tx     : i_rx;
  assign rx_sample_stb = loopback ? i_tx_stb : i_rx_stb;

  radio_settings #(
    .RADIO_NUM(RADIO_NUM)
  ) u_settings (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .i_rb_addr(i_rb_addr), .i_vita_time(i_vita_time), .i_rx(i_rx), .i_tx(o_tx),
    .o_loopback(loopback), .o_tx_idle(tx_idle), .o_rb_data(o_rb_data));

  radio_tx_ctrl u_tx_ctrl (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_clear(i_clear_tx),
    .i_tx_stb(i_tx_stb), .i_tx_idle(tx_idle), .i_vita_time(i_vita_time),
    .i_resp_sid({i_src_sid, i_tx_resp_dst_sid}),
    .i_tx_tdata(i_tx_tdata), .i_tx_tlast(i_tx_tlast),
    .i_tx_tvalid(i_tx_tvalid), .o_tx_tready(o_tx_tready), .o_tx(o_tx),
    .o_resp_tdata(txresp_tdata), .o_resp_tlast(txresp_tlast),
    .o_resp_tvalid(txresp_tvalid), .i_resp_tready(txresp_tready));

  radio_rx_ctrl u_rx_ctrl (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_clear(i_clear_rx),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .i_rx_stb(rx_sample_stb), .i_rx(rx_sample), .i_vita_time(i_vita_time),
    .i_resp_sid({i_src_sid, i_rx_resp_dst_sid}),
    .o_rx_tdata(o_rx_tdata), .o_rx_tlast(o_rx_tlast),
    .o_rx_tvalid(o_rx_tvalid), .i_rx_tready(i_rx_tready),
    .o_resp_tdata(rxresp_tdata), .o_resp_tlast(rxresp_tlast),
    .o_resp_tvalid(rxresp_tvalid), .i_resp_tready(rxresp_tready));

  // Whole packets only, alternating when both are waiting
  radio_resp_mux u_resp_mux (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_tx_resp_tdata(txresp_tdata), .i_tx_resp_tlast(txresp_tlast),
    .i_tx_resp_tvalid(txresp_tvalid), .o_tx_resp_tready(txresp_tready),
    .i_rx_resp_tdata(rxresp_tdata), .i_rx_resp_tlast(rxresp_tlast),
    .i_rx_resp_tvalid(rxresp_tvalid), .o_rx_resp_tready(rxresp_tready),
    .o_resp_tdata(o_resp_tdata), .o_resp_tlast(o_resp_tlast),
    .o_resp_tvalid(o_resp_tvalid), .i_resp_tready(i_resp_tready));

endmodule

/* radio_pkg.sv */
// Settings and readback addresses, RX command fields, response codes, widths, response word union
package radio_pkg;

  // Data path widths
  localparam int SAMPLE_W = 32;
  localparam int TIME_W   = 64;
  localparam int RESP_W   = 64;

  // Settings bus register addresses
  localparam logic [7:0] SR_LOOPBACK   = 8'd8;
  localparam logic [7:0] SR_TEST       = 8'd9;
  localparam logic [7:0] SR_CODEC_IDLE = 8'd10;
  localparam logic [7:0] SR_RX_MAXLEN  = 8'd100;
  localparam logic [7:0] SR_RX_CMD     = 8'd101;

  // RX command word layout
  localparam int RX_CMD_CONT_BIT = 31;
  localparam int RX_CMD_STOP_BIT = 30;
  localparam int RX_NSAMP_W      = 28;
  localparam int RX_MAXLEN_W     = 16;

  // Readback addresses
  localparam logic [7:0] RB_VITA_TIME = 8'd0;
  localparam logic [7:0] RB_TEST      = 8'd2;
  localparam logic [7:0] RB_TXRX      = 8'd3;
  localparam logic [7:0] RB_RADIO_NUM = 8'd4;

  // Response packet codes
  localparam logic [7:0] RESP_ACK       = 8'd1;
  localparam logic [7:0] RESP_UNDERFLOW = 8'd2;
  localparam logic [7:0] RESP_OVERFLOW  = 8'd8;
  localparam logic [7:0] RESP_CMD_DONE  = 8'd16;

  // Word 0 of a response is the header view, word 1 the raw VITA time
  typedef union packed {
    struct packed {
      logic [7:0]  code;
      logic [7:0]  reserved;
      // Counts packets per source
      logic [15:0] seqnum;
      // Source SID in the upper half, response destination below
      logic [31:0] sid;
    } hdr;
    logic [TIME_W-1:0] vtime;
  } resp_word_u;

endpackage

/* radio_resp_mux.sv */
// Packet-locked round-robin merge of the TX and RX response streams
`timescale 1ns/1ns
module radio_resp_mux (
  input  logic                         i_clk,
  input  logic                         i_rst_n,
  input  logic [radio_pkg::RESP_W-1:0] i_tx_resp_tdata,
  input  logic                         i_tx_resp_tlast,
  input  logic                         i_tx_resp_tvalid,
  output logic                         o_tx_resp_tready,
  input  logic [radio_pkg::RESP_W-1:0] i_rx_resp_tdata,
  input  logic                         i_rx_resp_tlast,
  input  logic                         i_rx_resp_tvalid,
  output logic                         o_rx_resp_tready,
  output logic [radio_pkg::RESP_W-1:0] o_resp_tdata,
  output logic                         o_resp_tlast,
  output logic                         o_resp_tvalid,
  input  logic                         i_resp_tready
);

  // Set between the first and the last word of a packet
  logic locked;
  // Source of the latest accepted word, 1 is RX
  logic last_win;
  logic sel;

  always_comb begin
    if (locked) begin
      sel = last_win;
    end else if (i_tx_resp_tvalid && i_rx_resp_tvalid) begin
      // Both waiting, favour the one that lost last time
      sel = !last_win;
    end else begin
      sel = i_rx_resp_tvalid;
    end
  end

  // Zero-latency path
  assign o_resp_tdata     = sel ? i_rx_resp_tdata  : i_tx_resp_tdata;
  assign o_resp_tlast     = sel ? i_rx_resp_tlast  : i_tx_resp_tlast;
  assign o_resp_tvalid    = sel ? i_rx_resp_tvalid : i_tx_resp_tvalid;
  assign o_tx_resp_tready = !sel && i_resp_tready;
  assign o_rx_resp_tready = sel && i_resp_tready;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      locked   <= 1'b0;
      // TX wins the first tie
      last_win <= 1'b1;
    end else if (o_resp_tvalid && i_resp_tready) begin
      locked   <= !o_resp_tlast;
      last_win <= sel;
    end
  end

  // Sources keep their second word ready, so a packet never stalls half way
  a_grant_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_resp_tvalid && i_resp_tready && !o_resp_tlast |=> o_resp_tvalid && (sel == $past(sel)));

endmodule

/* radio_rx_ctrl.sv */
// RX command engine, packet framing, overflow detection and response packets
`timescale 1ns/1ns
module radio_rx_ctrl (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic                           i_clear,
  input  logic                           i_set_stb,
  input  logic [7:0]                     i_set_addr,
  input  logic [31:0]                    i_set_data,
  input  logic                           i_rx_stb,
  input  logic [radio_pkg::SAMPLE_W-1:0] i_rx,
  input  logic [radio_pkg::TIME_W-1:0]   i_vita_time,
  input  logic [31:0]                    i_resp_sid,
  output logic [radio_pkg::SAMPLE_W-1:0] o_rx_tdata,
  output logic                           o_rx_tlast,
  output logic                           o_rx_tvalid,
  input  logic                           i_rx_tready,
  output logic [radio_pkg::RESP_W-1:0]   o_resp_tdata,
  output logic                           o_resp_tlast,
  output logic                           o_resp_tvalid,
  input  logic                           i_resp_tready
);
  import radio_pkg::*;

  logic                   run;
  logic                   cont;
  logic                   stop_req;
  logic [RX_NSAMP_W-1:0]  remain;
  logic [RX_MAXLEN_W-1:0] maxlen;
  logic [RX_MAXLEN_W-1:0] pkt_cnt;
  logic                   cmd_pulse;
  logic                   stb;
  logic                   full;
  logic                   pkt_end;
  logic                   final_smp;
  logic                   take;
  logic                   overflow;
  logic                   done;
  logic                   resp_sel;
  logic [7:0]             resp_code;
  logic [TIME_W-1:0]      resp_time;
  logic [15:0]            seqnum;
  resp_word_u             resp_word;

  // One-cycle command pulse straight off the settings bus
  assign cmd_pulse = i_set_stb && (i_set_addr == SR_RX_CMD);
  // A strobe coinciding with a command write is skipped
  assign stb       = run && i_rx_stb && !cmd_pulse;
  // Output register still holds a word that will not leave this edge
  assign full      = o_rx_tvalid && !i_rx_tready;
  assign pkt_end   = pkt_cnt == maxlen - 1'b1;
  assign final_smp = !cont && (remain == RX_NSAMP_W'(1));
  assign take      = stb && !full;
  assign overflow  = stb && full;
  assign done      = take && final_smp;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      maxlen <= '0;
    end else if (i_set_stb && (i_set_addr == SR_RX_MAXLEN)) begin
      maxlen <= i_set_data[RX_MAXLEN_W-1:0];
    end
  end

  // Command engine
  always_ff @(posedge i_clk) begin
    if (!i_rst_n || i_clear) begin
      run      <= 1'b0;
      stop_req <= 1'b0;
      pkt_cnt  <= '0;
    end else if (cmd_pulse) begin
      if (i_set_data[RX_CMD_STOP_BIT]) begin
        // Stop waits for the current packet to close
        stop_req <= run;
      end else begin
        run      <= 1'b1;
        cont     <= i_set_data[RX_CMD_CONT_BIT];
        remain   <= i_set_data[RX_NSAMP_W-1:0];
        pkt_cnt  <= '0;
        stop_req <= 1'b0;
      end
    end else if (overflow) begin
      run <= 1'b0;
    end else if (take) begin
      pkt_cnt <= pkt_end ? '0 : pkt_cnt + 1'b1;
      remain  <= remain - 1'b1;
      if (final_smp || (pkt_end && stop_req)) begin
        run      <= 1'b0;
        stop_req <= 1'b0;
      end
    end
  end

  // One-word output register
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_rx_tvalid <= 1'b0;
    end else if (take) begin
      o_rx_tvalid <= 1'b1;
    end else if (i_rx_tready) begin
      o_rx_tvalid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (take) begin
      o_rx_tdata <= i_rx;
      o_rx_tlast <= pkt_end || final_smp;
    end
  end

  // Response sequencer, same 2-word shape as TX
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_resp_tvalid <= 1'b0;
      resp_sel      <= 1'b0;
      seqnum        <= '0;
    end else if (o_resp_tvalid) begin
      if (i_resp_tready) begin
        resp_sel <= !resp_sel;
        if (resp_sel) begin
          o_resp_tvalid <= 1'b0;
          seqnum        <= seqnum + 16'd1;
        end
      end
    end else if (overflow || done) begin
      o_resp_tvalid <= 1'b1;
      resp_sel      <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!o_resp_tvalid && (overflow || done)) begin
      resp_code <= overflow ? RESP_OVERFLOW : RESP_CMD_DONE;
      resp_time <= i_vita_time;
    end
  end

  always_comb begin
    if (resp_sel) begin
      resp_word.vtime = resp_time;
    end else begin
      resp_word.hdr.code     = resp_code;
      resp_word.hdr.reserved = 8'd0;
      resp_word.hdr.seqnum   = seqnum;
      resp_word.hdr.sid      = i_resp_sid;
    end
  end

  assign o_resp_tdata = resp_word;
  assign o_resp_tlast = resp_sel;

  // Downstream stalls must never lose or overwrite a sample already offered
  a_rx_valid_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_rx_tvalid && !i_rx_tready |=>
      o_rx_tvalid && $stable(o_rx_tdata) && $stable(o_rx_tlast));

endmodule

/* radio_settings.sv */
// Shared settings registers (loopback, test, TX idle) and the combinational readback mux
`timescale 1ns/1ns
module radio_settings #(
  parameter int RADIO_NUM = 0
) (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic                           i_set_stb,
  input  logic [7:0]                     i_set_addr,
  input  logic [31:0]                    i_set_data,
  input  logic [7:0]                     i_rb_addr,
  input  logic [radio_pkg::TIME_W-1:0]   i_vita_time,
  input  logic [radio_pkg::SAMPLE_W-1:0] i_rx,
  input  logic [radio_pkg::SAMPLE_W-1:0] i_tx,
  output logic                           o_loopback,
  output logic [radio_pkg::SAMPLE_W-1:0] o_tx_idle,
  output logic [63:0]                    o_rb_data
);
  import radio_pkg::*;

  logic [31:0] test_word;

  // Register writes land on the strobe edge
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_loopback <= 1'b0;
      test_word  <= '0;
      // DAC sees zero until an idle word is written
      o_tx_idle  <= '0;
    end else if (i_set_stb) begin
      case (i_set_addr)
        SR_LOOPBACK:   o_loopback <= i_set_data[0];
        SR_TEST:       test_word  <= i_set_data;
        SR_CODEC_IDLE: o_tx_idle  <= i_set_data;
        default:       ;
      endcase
    end
  end

  // Readback is a plain mux on the address, no wait state
  always_comb begin
    case (i_rb_addr)
      RB_VITA_TIME: o_rb_data = i_vita_time;
      // Live converter sample next to the test word
      RB_TEST:      o_rb_data = {i_rx, test_word};
      RB_TXRX:      o_rb_data = {i_tx, i_rx};
      RB_RADIO_NUM: o_rb_data = {32'd0, 32'(RADIO_NUM)};
      // Anything else reads as zero
      default:      o_rb_data = '0;
    endcase
  end

  // Converter inputs and time feed the mux, so X there would leak to the host
  a_rb_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !$isunknown(o_rb_data));

endmodule

/* radio_tx_ctrl.sv */
// TX burst player with idle word, underflow and burst-end response packets
`timescale 1ns/1ns
module radio_tx_ctrl (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic                           i_clear,
  input  logic                           i_tx_stb,
  input  logic [radio_pkg::SAMPLE_W-1:0] i_tx_idle,
  input  logic [radio_pkg::TIME_W-1:0]   i_vita_time,
  input  logic [31:0]                    i_resp_sid,
  input  logic [radio_pkg::SAMPLE_W-1:0] i_tx_tdata,
  input  logic                           i_tx_tlast,
  input  logic                           i_tx_tvalid,
  output logic                           o_tx_tready,
  output logic [radio_pkg::SAMPLE_W-1:0] o_tx,
  output logic [radio_pkg::RESP_W-1:0]   o_resp_tdata,
  output logic                           o_resp_tlast,
  output logic                           o_resp_tvalid,
  input  logic                           i_resp_tready
);
  import radio_pkg::*;

  logic                run;
  logic                eob;
  logic [SAMPLE_W-1:0] sample;
  logic                underflow;
  logic                eob_hit;
  logic                resp_sel;
  logic [7:0]          resp_code;
  logic [TIME_W-1:0]   resp_time;
  logic [15:0]         seqnum;
  resp_word_u          resp_word;

  // Ready only on a strobe, and never once a burst end or a response is outstanding
  assign o_tx_tready = i_tx_stb && !eob && !o_resp_tvalid;
  // Strobe with nothing to play while running
  assign underflow   = i_tx_stb && run && !eob && !i_tx_tvalid;
  // Strobe after the tlast sample closes the burst
  assign eob_hit     = i_tx_stb && eob;

  // Burst state
  always_ff @(posedge i_clk) begin
    if (!i_rst_n || i_clear) begin
      run <= 1'b0;
      eob <= 1'b0;
    end else if (o_tx_tready && i_tx_tvalid) begin
      run <= 1'b1;
      eob <= i_tx_tlast;
    end else if (underflow || eob_hit) begin
      run <= 1'b0;
      eob <= 1'b0;
    end
  end

  // Sample holds between strobes
  always_ff @(posedge i_clk) begin
    if (o_tx_tready && i_tx_tvalid) begin
      sample <= i_tx_tdata;
    end
  end

  assign o_tx = run ? sample : i_tx_idle;

  // Response word sequencer: hdr first, then time with tlast
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_resp_tvalid <= 1'b0;
      resp_sel      <= 1'b0;
      seqnum        <= '0;
    end else if (o_resp_tvalid) begin
      if (i_resp_tready) begin
        resp_sel <= !resp_sel;
        if (resp_sel) begin
          o_resp_tvalid <= 1'b0;
          seqnum        <= seqnum + 16'd1;
        end
      end
    end else if (underflow || eob_hit) begin
      o_resp_tvalid <= 1'b1;
      resp_sel      <= 1'b0;
    end
  end

  // Latch code and event time
  always_ff @(posedge i_clk) begin
    if (!o_resp_tvalid && (underflow || eob_hit)) begin
      resp_code <= eob_hit ? RESP_ACK : RESP_UNDERFLOW;
      resp_time <= i_vita_time;
    end
  end

  always_comb begin
    if (resp_sel) begin
      resp_word.vtime = resp_time;
    end else begin
      resp_word.hdr.code     = resp_code;
      resp_word.hdr.reserved = 8'd0;
      resp_word.hdr.seqnum   = seqnum;
      resp_word.hdr.sid      = i_resp_sid;
    end
  end

  assign o_resp_tdata = resp_word;
  assign o_resp_tlast = resp_sel;

  // The mux may stall us for many cycles; word and valid must hold
  a_resp_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_resp_tvalid && !i_resp_tready |=> o_resp_tvalid && $stable(o_resp_tdata));

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build the radio core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_radio_core -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^SIMULATION PASSED$"; then
  exit 0
fi
exit 1

/* tb_radio_core.sv */
// Testbench for radio_core: clock, strobes, LFSR stimulus, reference header model, checks, watchdog
`timescale 1ns/1ns
module tb_radio_core;
  import radio_pkg::*;

  localparam int CLK_NS   = 4;
  localparam int RADIO_ID = 3;
  localparam int N_BURST  = 6;
  localparam int M_RX     = 7;
  // TX burst, underflow pair, RX command, overflow pair
  localparam int N_DRIVEN        = N_BURST + 2 + M_RX + 2;
  localparam int WATCHDOG_CYCLES = N_DRIVEN * 40 + 200;
  localparam logic [15:0] SRC_SID = 16'h0042;
  localparam logic [15:0] TX_DST  = 16'h0011;
  localparam logic [15:0] RX_DST  = 16'h0022;

  logic                i_clk = 1'b0;
  logic                i_rst_n;
  logic                i_clear_tx;
  logic                i_clear_rx;
  logic [15:0]         i_src_sid;
  logic [15:0]         i_tx_resp_dst_sid;
  logic [15:0]         i_rx_resp_dst_sid;
  logic [TIME_W-1:0]   i_vita_time;
  logic [SAMPLE_W-1:0] i_rx;
  logic                i_rx_stb;
  logic [SAMPLE_W-1:0] o_tx;
  logic                i_tx_stb;
  logic                i_set_stb;
  logic [7:0]          i_set_addr;
  logic [31:0]         i_set_data;
  logic [7:0]          i_rb_addr;
  logic [63:0]         o_rb_data;
  logic [SAMPLE_W-1:0] i_tx_tdata;
  logic                i_tx_tlast;
  logic                i_tx_tvalid;
  logic                o_tx_tready;
  logic [SAMPLE_W-1:0] o_rx_tdata;
  logic                o_rx_tlast;
  logic                o_rx_tvalid;
  logic                i_rx_tready;
  logic [RESP_W-1:0]   o_resp_tdata;
  logic                o_resp_tlast;
  logic                o_resp_tvalid;
  logic                i_resp_tready;

  logic [15:0]         lfsr = 16'd58;
  logic [1:0]          stb_phase = 2'd0;
  logic                rx_hold = 1'b0;
  int                  tx_acc = 0;
  logic                in_time = 1'b0;
  logic [TIME_W-1:0]   last_time = '0;
  logic [15:0]         tx_seq = '0;
  logic [15:0]         rx_seq = '0;
  logic [SAMPLE_W-1:0] smp [0:31];
  // Expected RX words and response codes, in arrival order
  logic [SAMPLE_W-1:0] exp_rx_data [$];
  logic                exp_rx_last [$];
  logic [7:0]          exp_code [$];

  radio_core #(.RADIO_NUM(RADIO_ID)) u_dut (.*);

  always #(CLK_NS / 2) i_clk = ~i_clk;

  // Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic is_tx_code(input logic [7:0] code);
    return (code == RESP_ACK) || (code == RESP_UNDERFLOW);
  endfunction

  // Header a source should emit for this event and its own packet count
  function automatic resp_word_u ref_hdr(input logic [7:0] code, input logic [15:0] seq);
    resp_word_u w;
    w.hdr.code     = code;
    w.hdr.reserved = 8'd0;
    w.hdr.seqnum   = seq;
    w.hdr.sid      = {SRC_SID, is_tx_code(code) ? TX_DST : RX_DST};
    return w;
  endfunction

  task automatic die(input string msg);
    $display("SIMULATION FAILED");
    $fatal(1, "%s", msg);
  endtask

  task automatic check_sample(input string name, input logic [SAMPLE_W-1:0] got,
                              input logic [SAMPLE_W-1:0] exp);
    if (got !== exp) begin
      $display("Fail t=%0t %s got %h expected %h", $time, name, got, exp);
      die({name, " does not match the expected value"});
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail t=%0t %s got %b expected %b", $time, name, got, exp);
      die({name, " does not match the expected value"});
    end
  endtask

  task automatic check_resp(input string name, input resp_word_u got, input resp_word_u exp);
    if (got.hdr !== exp.hdr) begin
      $display("Fail t=%0t %s got %h expected %h", $time, name, got.hdr, exp.hdr);
      die({name, " header does not match the expected value"});
    end
  endtask

  task automatic check_rb(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Fail t=%0t %s got %h expected %h", $time, name, got, exp);
      die({name, " does not match the expected value"});
    end
  endtask

  task automatic fill_samples();
    for (int i = 0; i < 32; i++) begin
      for (int b = 0; b < SAMPLE_W; b++) begin
        lfsr      = lfsr_step(lfsr);
        smp[i][b] = lfsr[0];
      end
    end
  endtask

  // Next falling edge; a settings write lasts one cycle
  task automatic tick();
    @(negedge i_clk);
    i_set_stb = 1'b0;
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    i_set_stb  = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
    tick();
  endtask

  task automatic read_check(input logic [7:0] addr, input logic [63:0] exp);
    i_rb_addr = addr;
    #1;
    check_rb("o_rb_data", o_rb_data, exp);
    tick();
  endtask

  // Returns on the falling edge right after a strobe edge
  task automatic wait_strobe_edge();
    do @(posedge i_clk); while (!i_rx_stb);
    tick();
  endtask

  task automatic expect_rx(input logic [SAMPLE_W-1:0] d, input logic last);
    exp_rx_data.push_back(d);
    exp_rx_last.push_back(last);
  endtask

  task automatic send_tx(input logic [SAMPLE_W-1:0] d, input logic last);
    int n;
    n           = tx_acc;
    i_tx_tdata  = d;
    i_tx_tlast  = last;
    i_tx_tvalid = 1'b1;
    while (tx_acc == n) tick();
    i_tx_tvalid = 1'b0;
  endtask

  // Command write, then one converter word per strobe; only the first keep are expected
  task automatic run_rx(input logic [31:0] cmd, input int n, input int keep, input int len);
    wait_strobe_edge();
    write_reg(SR_RX_CMD, cmd);
    for (int k = 0; k < n; k++) begin
      i_rx = smp[10 + k];
      if (k < keep) begin
        expect_rx(smp[10 + k], ((k + 1) % len == 0) || (!cmd[RX_CMD_CONT_BIT] && k == n - 1));
      end
      wait_strobe_edge();
    end
  endtask

  task automatic drain();
    while (exp_code.size() != 0 || exp_rx_data.size() != 0) tick();
  endtask

  // Strobes every 3rd cycle, free-running time, random ready gaps
  always @(negedge i_clk) begin
    stb_phase   = (stb_phase == 2'd2) ? 2'd0 : stb_phase + 2'd1;
    i_tx_stb    = (stb_phase == 2'd2);
    i_rx_stb    = (stb_phase == 2'd2);
    i_vita_time = i_vita_time + 1'b1;
    lfsr        = lfsr_step(lfsr);
    // Ready is forced on strobe cycles so the one-word register never overflows
    i_rx_tready = !rx_hold && (i_rx_stb || lfsr[0]);
    lfsr        = lfsr_step(lfsr);
    i_resp_tready = lfsr[0];
  end

  // Compare process, samples just after inputs settle
  always @(negedge i_clk) begin
    resp_word_u got;
    logic [7:0] code;
    #1;
    if (i_tx_tvalid && o_tx_tready) tx_acc++;
    if (o_rx_tvalid && i_rx_tready) begin
      if (exp_rx_data.size() == 0) begin
        die("RX stream delivered a sample that was not expected");
      end else begin
        check_sample("o_rx_tdata", o_rx_tdata, exp_rx_data.pop_front());
        check_flag("o_rx_tlast", o_rx_tlast, exp_rx_last.pop_front());
      end
    end
    if (o_resp_tvalid && i_resp_tready) begin
      got = o_resp_tdata;
      if (exp_code.size() == 0) begin
        die("a response packet arrived that was not expected");
      end else if (!in_time) begin
        code = exp_code[0];
        check_flag("o_resp_tlast", o_resp_tlast, 1'b0);
        check_resp("o_resp_tdata", got, ref_hdr(code, is_tx_code(code) ? tx_seq : rx_seq));
        in_time = 1'b1;
      end else begin
        check_flag("o_resp_tlast", o_resp_tlast, 1'b1);
        if (got.vtime < last_time) die("response time went backwards");
        last_time = got.vtime;
        code      = exp_code.pop_front();
        if (is_tx_code(code)) tx_seq++;
        else rx_seq++;
        in_time = 1'b0;
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_NS);
    die("Timeout, the tests did not finish in the allowed time");
  end

  initial begin
    i_rst_n = 1'b0;
    i_clear_tx = 1'b0;
    i_clear_rx = 1'b0;
    i_src_sid = SRC_SID;
    i_tx_resp_dst_sid = TX_DST;
    i_rx_resp_dst_sid = RX_DST;
    i_vita_time = '0;
    i_rx = '0;
    i_rx_stb = 1'b0;
    i_tx_stb = 1'b0;
    i_set_stb = 1'b0;
    i_set_addr = '0;
    i_set_data = '0;
    i_rb_addr = '0;
    i_tx_tdata = '0;
    i_tx_tlast = 1'b0;
    i_tx_tvalid = 1'b0;
    i_rx_tready = 1'b0;
    i_resp_tready = 1'b0;
    fill_samples();
    repeat (5) @(negedge i_clk);
    i_rst_n = 1'b1;

    // Readback of every address, idle word smp[30]
    write_reg(SR_TEST, smp[29]);
    write_reg(SR_CODEC_IDLE, smp[30]);
    i_rx = smp[31];
    read_check(RB_TEST, {smp[31], smp[29]});
    read_check(RB_TXRX, {smp[30], smp[31]});
    read_check(RB_RADIO_NUM, 64'(RADIO_ID));
    read_check(8'd7, 64'd0);
    i_rb_addr = RB_VITA_TIME;
    #1;
    check_rb("o_rb_data", o_rb_data, i_vita_time);
    tick();

    // Loopback burst, RX armed right after the first sample leaves
    write_reg(SR_LOOPBACK, 32'd1);
    write_reg(SR_RX_MAXLEN, 32'd4);
    for (int i = 0; i < N_BURST; i++) expect_rx(smp[i], ((i + 1) % 4 == 0) || (i == N_BURST - 1));
    // Both responses fire on one strobe, TX takes the first tie
    exp_code.push_back(RESP_ACK);
    exp_code.push_back(RESP_CMD_DONE);
    send_tx(smp[0], 1'b0);
    i_set_stb  = 1'b1;
    i_set_addr = SR_RX_CMD;
    i_set_data = 32'(N_BURST);
    for (int i = 1; i < N_BURST; i++) send_tx(smp[i], i == N_BURST - 1);
    drain();
    check_sample("o_tx", o_tx, smp[30]);

    // Underflow in mid-burst
    exp_code.push_back(RESP_UNDERFLOW);
    send_tx(smp[8], 1'b0);
    send_tx(smp[9], 1'b0);
    check_sample("o_tx", o_tx, smp[9]);
    drain();
    check_sample("o_tx", o_tx, smp[30]);

    // Counted RX command from the converter input
    write_reg(SR_LOOPBACK, 32'd0);
    write_reg(SR_RX_MAXLEN, 32'd3);
    exp_code.push_back(RESP_CMD_DONE);
    run_rx(32'(M_RX), M_RX, M_RX, 3);
    drain();

    // Continuous RX with the host stalled, second word overflows
    rx_hold <= 1'b1;
    exp_code.push_back(RESP_OVERFLOW);
    run_rx(32'h8000_0000, 2, 1, 3);
    repeat (3) wait_strobe_edge();
    rx_hold <= 1'b0;
    drain();
    repeat (3) wait_strobe_edge();

    if (exp_rx_data.size() != 0 || exp_code.size() != 0) begin
      die("expected stream words were never delivered");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule
